// File: src/cmp_rx_pkg.sv
`default_nettype none

package cmp_rx_pkg;

	// ----------------------------------------
	// Protocol constants
	// ----------------------------------------
	localparam int word_w = 16;                  // One received word
	localparam int frame_words = 3;              // Data words per bunch crossing
	localparam logic [1:0] k_low_isk = 2'b01;    // Marker: K in low byte only
	localparam logic [7:0] ltncy_char = 8'hFC;   // Latency trigger K-char
	localparam logic [3:0] eof_nibble = 4'hE;    // Bits 4..1 of a valid EOF K-char
	localparam logic [3:0] err_sat_hi = 4'hE;    // Loss counter stops here (upper nibble)

	// ----------------------------------------
	// Word and lane types
	// ----------------------------------------
	// K-char view of a word
	typedef struct packed {
		logic [7:0] upper;   // Free data byte in the EOF word
		logic [7:0] kchar;   // K-character, low byte
	} rx_char_t;

	// Same 16 bits, data or marker reading
	typedef union packed {
		logic [word_w-1:0] data;
		rx_char_t          chr;
	} rx_word_t;

	// What the transceiver hands over each cycle
	typedef struct packed {
		rx_word_t   word;
		logic [1:0] isk;            // Char-is-K, per byte
		logic [1:0] notintable;     // 8b10b code not in table
		logic [1:0] disperr;        // Running disparity error
		logic       lossofsync_hi;  // Upper loss-of-sync bit
	} rx_lane_t;

	// Slot strobes of one bunch crossing
	typedef struct packed {
		logic cew0;   // Marker slot
		logic cew1;
		logic cew2;
		logic cew3;
	} slot_t;

	// ----------------------------------------
	// Frame and link types
	// ----------------------------------------
	typedef struct packed {
		logic [word_w*frame_words-1:0] data;     // Word 3 high, word 1 low
		logic [frame_words-1:0]        nonzero;  // Bit i set when word i+1 nonzero
		logic                          ltncy_trig;
	} frame_t;

	typedef struct packed {
		logic       link_good;
		logic       link_had_err;
		logic       link_bad;
		logic [7:0] err_count;   // Times the link was lost
	} link_status_t;

endpackage

`default_nettype wire

// File: src/cmp_rx_lane_ctrl.sv
`default_nettype none

module cmp_rx_lane_ctrl (
	input  wire  CMP_RX_CLK160,
	input  wire  cmp_rx_resetdone,   // Async, active low
	input  wire  byte_aligned,
	input  wire  sync_done,          // From external phase aligner
	input  wire  ttc_resync,
	output logic rst_done,
	output logic phase_align_rst,
	output logic calign,
	output logic rx_clear
);

	logic resetdone_q;   // First sync stage

	// Reset-done double sync, phase-align reset trails it by one edge
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			resetdone_q     <= 1'b0;
			rst_done        <= 1'b0;
			phase_align_rst <= 1'b1;   // Hold aligner in reset
			calign          <= 1'b1;   // Hunt for commas from the start
		end else begin
			resetdone_q     <= 1'b1;
			rst_done        <= resetdone_q;
			phase_align_rst <= !rst_done;
			calign          <= !byte_aligned;   // Comma align until bytes lock
		end
	end

	// Data path clear, no phase sync yet or resync from TTC
	assign rx_clear = !sync_done || ttc_resync;

endmodule

`default_nettype wire

// File: src/cmp_rx_slot_timer.sv
`default_nettype none

module cmp_rx_slot_timer (
	input  wire                  CMP_RX_CLK160,
	input  wire                  cmp_rx_resetdone,
	input  wire cmp_rx_pkg::rx_lane_t lane,
	output cmp_rx_pkg::slot_t    slots
);

	logic marker;   // EOF K-word seen this cycle

	// Only the low byte flagged as K
	assign marker = (lane.isk == cmp_rx_pkg::k_low_isk);

	// ----------------------------------------
	// Four-slot ring
	// ----------------------------------------
	// Marker at edge n gives cew1 in n+1, then cew2, cew3, cew0
	// A fresh marker reloads cew1 while older bits keep moving
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			slots <= '0;
		end else begin
			slots.cew1 <= marker;       // First data word next
			slots.cew2 <= slots.cew1;
			slots.cew3 <= slots.cew2;   // Last data word
			slots.cew0 <= slots.cew3;   // Where the next marker belongs
		end
	end

endmodule

`default_nettype wire

// File: src/cmp_rx_frame_assembler.sv
`default_nettype none

module cmp_rx_frame_assembler (
	input  wire                       CMP_RX_CLK160,
	input  wire                       cmp_rx_resetdone,
	input  wire                       rx_clear,
	input  wire cmp_rx_pkg::rx_lane_t lane,
	input  wire cmp_rx_pkg::slot_t    slots,
	output cmp_rx_pkg::frame_t        frame,
	output logic                      frame_valid
);

	logic [cmp_rx_pkg::word_w-1:0] w1;   // First data word
	logic [cmp_rx_pkg::word_w-1:0] w2;   // Second data word
	logic                          lt_pending;
	logic                          lt_hit;

	// Marker word that carries the latency trigger
	assign lt_hit = (lane.isk == cmp_rx_pkg::k_low_isk) &&
		(lane.word.chr.kchar == cmp_rx_pkg::ltncy_char);

	// ----------------------------------------
	// Word capture
	// ----------------------------------------
	always_ff @(posedge CMP_RX_CLK160) begin
		if (slots.cew1)
			w1 <= lane.word.data;
		if (slots.cew2)
			w2 <= lane.word.data;
	end

	// ----------------------------------------
	// Frame output, one cycle after cew3
	// ----------------------------------------
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			lt_pending  <= 1'b0;
			frame       <= '0;
			frame_valid <= 1'b0;
		end else if (rx_clear) begin
			lt_pending  <= 1'b0;   // First frame after clear has no trigger
			frame       <= '0;
			frame_valid <= 1'b0;
		end else begin
			// Marker sitting in the cew0 slot, otherwise no trigger
			if (slots.cew0)
				lt_pending <= lt_hit;

			frame_valid <= slots.cew3;
			if (slots.cew3) begin
				frame.data       <= {lane.word.data, w2, w1};   // Word 3 on top
				frame.nonzero    <= {|lane.word.data, |w2, |w1};
				frame.ltncy_trig <= lt_pending;
			end else begin
				frame <= '0;   // Idle frame reads zero
			end
		end
	end

endmodule

`default_nettype wire

// File: src/cmp_rx_link_monitor.sv
`default_nettype none

module cmp_rx_link_monitor #(
	parameter int lock_frames = 15   // Clean frames before link_good
) (
	input  wire                       CMP_RX_CLK160,
	input  wire                       cmp_rx_resetdone,
	input  wire                       rx_clear,
	input  wire cmp_rx_pkg::rx_lane_t lane,
	input  wire cmp_rx_pkg::slot_t    slots,
	output cmp_rx_pkg::link_status_t  link
);

	localparam int lock_w = $clog2(lock_frames + 1);
	localparam logic [lock_w-1:0] lock_max = lock_w'(lock_frames);

	logic [3:0]        health;      // One bit per slot of the last frame
	logic              unsettled;   // Last frame not fully clean
	logic [lock_w-1:0] lock_cnt;
	logic              link_good;
	logic              link_err;    // Link was lost at least once
	logic [7:0]        err_count;
	logic              went_down;
	logic              marker_ok;
	logic              data_ok;

	// ----------------------------------------
	// Per-slot health checks
	// ----------------------------------------
	assign marker_ok = !lane.lossofsync_hi && (lane.isk == cmp_rx_pkg::k_low_isk) &&
		(lane.notintable == 2'b00) && (lane.word.chr.kchar[4:1] == cmp_rx_pkg::eof_nibble);
	assign data_ok = !lane.lossofsync_hi && (lane.notintable == 2'b00) &&
		(lane.isk == 2'b00);   // Data slots carry no K

	assign went_down = link_good && unsettled;

	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			health    <= '0;
			unsettled <= 1'b1;
			lock_cnt  <= '0;
			link_good <= 1'b0;
			link_err  <= 1'b0;
			err_count <= '0;
		end else if (rx_clear) begin
			health    <= '0;
			unsettled <= 1'b1;
			lock_cnt  <= '0;
			link_good <= 1'b0;
			link_err  <= 1'b0;
			err_count <= '0;
		end else begin
			if (slots.cew0)
				health[0] <= marker_ok;
			else if (slots.cew1)
				health[1] <= data_ok && !slots.cew2 && !slots.cew3;   // No stray marker
			else if (slots.cew2)
				health[2] <= data_ok && !slots.cew3;
			else if (slots.cew3)
				health[3] <= data_ok;
			else
				health <= '0;   // Gap in the slot train

			unsettled <= (health != 4'hF);

			// Lock counter, one step per clean frame
			if (unsettled)
				lock_cnt <= '0;
			else if (!link_good && slots.cew3)
				lock_cnt <= lock_cnt + 1'b1;
			link_good <= !unsettled && (lock_cnt == lock_max);

			// Loss bookkeeping
			if (went_down)
				link_err <= 1'b1;
			if (went_down && (err_count[7:4] != cmp_rx_pkg::err_sat_hi))
				err_count <= err_count + 1'b1;
		end
	end

	// ----------------------------------------
	// Status out
	// ----------------------------------------
	assign link.link_good    = link_good;
	assign link.link_had_err = link_err || unsettled;   // Also never-alive
	assign link.link_bad     = err_count[7];
	assign link.err_count    = err_count;

endmodule

`default_nettype wire

// File: src/cmp_rx_code_err_counter.sv
`default_nettype none

module cmp_rx_code_err_counter #(
	parameter int code_cnt_w = 16
) (
	input  wire                       CMP_RX_CLK160,
	input  wire                       cmp_rx_resetdone,
	input  wire                       rx_clear,
	input  wire cmp_rx_pkg::rx_lane_t lane,
	input  wire cmp_rx_pkg::slot_t    slots,
	output logic [code_cnt_w-1:0]     notintable_count,
	output logic [code_cnt_w-1:0]     disperr_count
);

	// Stop one short of all ones
	localparam logic [code_cnt_w-1:0] cnt_sat = {{(code_cnt_w-1){1'b1}}, 1'b0};

	logic in_slot;   // Any strobe of the frame

	// Saturating step on a nonzero flag pair
	function automatic logic [code_cnt_w-1:0] sat_bump(input logic [code_cnt_w-1:0] cnt,
		input logic [1:0] flags);
		if ((flags != 2'b00) && (cnt != cnt_sat))
			return cnt + 1'b1;
		return cnt;
	endfunction

	assign in_slot = |slots;

	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			notintable_count <= '0;
			disperr_count    <= '0;
		end else if (rx_clear) begin
			notintable_count <= '0;
			disperr_count    <= '0;
		end else if (in_slot) begin
			notintable_count <= sat_bump(notintable_count, lane.notintable);
			disperr_count    <= sat_bump(disperr_count, lane.disperr);
		end
	end

endmodule

`default_nettype wire

// File: src/cmp_rx_fiber_in.sv
`default_nettype none

module cmp_rx_fiber_in #(
	parameter int lock_frames = 15,
	parameter int code_cnt_w  = 16
) (
	input  wire                       CMP_RX_CLK160,
	input  wire                       cmp_rx_resetdone,
	input  wire cmp_rx_pkg::rx_lane_t lane,
	input  wire                       byte_aligned,
	input  wire                       sync_done,
	input  wire                       ttc_resync,
	output logic                      rst_done,
	output logic                      phase_align_rst,
	output logic                      calign,
	output cmp_rx_pkg::slot_t         slots,
	output cmp_rx_pkg::frame_t        frame,
	output logic                      frame_valid,
	output cmp_rx_pkg::link_status_t  link,
	output logic [code_cnt_w-1:0]     notintable_count,
	output logic [code_cnt_w-1:0]     disperr_count
);

	logic rx_clear;   // Sync clear for the data path

	// ----------------------------------------
	// Lane control and slot timing
	// ----------------------------------------
	cmp_rx_lane_ctrl u_lane_ctrl (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.byte_aligned     (byte_aligned),
		.sync_done        (sync_done),
		.ttc_resync       (ttc_resync),
		.rst_done         (rst_done),
		.phase_align_rst  (phase_align_rst),
		.calign           (calign),
		.rx_clear         (rx_clear)
	);

	cmp_rx_slot_timer u_slot_timer (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.lane             (lane),
		.slots            (slots)
	);

	// ----------------------------------------
	// Data path
	// ----------------------------------------
	cmp_rx_frame_assembler u_frame_assembler (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.rx_clear         (rx_clear),
		.lane             (lane),
		.slots            (slots),
		.frame            (frame),
		.frame_valid      (frame_valid)
	);

	cmp_rx_link_monitor #(.lock_frames(lock_frames)) u_link_monitor (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.rx_clear         (rx_clear),
		.lane             (lane),
		.slots            (slots),
		.link             (link)
	);

	cmp_rx_code_err_counter #(.code_cnt_w(code_cnt_w)) u_code_err_counter (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.rx_clear         (rx_clear),
		.lane             (lane),
		.slots            (slots),
		.notintable_count (notintable_count),
		.disperr_count    (disperr_count)
	);

endmodule

`default_nettype wire

// File: tests/cmp_rx_fiber_in_properties.sv
`default_nettype none

module cmp_rx_fiber_in_properties (
	input wire                           CMP_RX_CLK160,
	input wire                           cmp_rx_resetdone,
	input wire                           rx_clear,
	input wire cmp_rx_pkg::slot_t        slots,
	input wire cmp_rx_pkg::frame_t       frame,
	input wire                           frame_valid,
	input wire cmp_rx_pkg::link_status_t link
);
	timeunit 1ns;
	timeprecision 1ps;

	int assert_fails = 0;   // Failed assertion count

	// ----------------------------------------
	// Slot ring and frame strobe
	// ----------------------------------------
	one_slot: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		$onehot0(slots))
		else begin
			$error("More than one slot strobe high at once");
			assert_fails = assert_fails + 1;
		end

	// Valid strobe only right after the last data slot
	valid_after_cew3: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		frame_valid |-> $past(slots.cew3))
		else begin
			$error("frame_valid without a cew3 cycle before it");
			assert_fails = assert_fails + 1;
		end

	cew3_gives_valid: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		slots.cew3 && !rx_clear |=> frame_valid)
		else begin
			$error("cew3 cycle not followed by frame_valid");
			assert_fails = assert_fails + 1;
		end

	idle_frame_zero: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		!frame_valid |-> (frame == '0))
		else begin
			$error("frame nonzero while frame_valid is low");
			assert_fails = assert_fails + 1;
		end

	// Link state wiped one edge into a clear
	clear_link: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		rx_clear |=> (!link.link_good && (link.err_count == 8'h00)))
		else begin
			$error("Link status still active during rx_clear");
			assert_fails = assert_fails + 1;
		end

endmodule

bind cmp_rx_fiber_in cmp_rx_fiber_in_properties props0 (
	.CMP_RX_CLK160    (CMP_RX_CLK160),
	.cmp_rx_resetdone (cmp_rx_resetdone),
	.rx_clear         (rx_clear),
	.slots            (slots),
	.frame            (frame),
	.frame_valid      (frame_valid),
	.link             (link)
);

`default_nettype wire

// File: tests/cmp_rx_fiber_in_tb.sv
`default_nettype none

module cmp_rx_fiber_in_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int lock_frames = 15;
	localparam int code_cnt_w  = 16;
	localparam int max_cycles  = 600;   // About four times the ~150 cycles of all tests

	logic                     CMP_RX_CLK160;
	logic                     cmp_rx_resetdone;
	cmp_rx_pkg::rx_lane_t     lane;
	logic                     byte_aligned;
	logic                     sync_done;
	logic                     ttc_resync;
	logic                     rst_done;
	logic                     phase_align_rst;
	logic                     calign;
	cmp_rx_pkg::slot_t        slots;
	cmp_rx_pkg::frame_t       frame;
	logic                     frame_valid;
	cmp_rx_pkg::link_status_t link;
	logic [code_cnt_w-1:0]    notintable_count;
	logic [code_cnt_w-1:0]    disperr_count;

	integer      seed;
	int          cycles = 0;
	string       test_name;
	logic [51:0] got_frames[$];   // Every frame seen on a valid strobe

	cmp_rx_fiber_in #(.lock_frames(lock_frames), .code_cnt_w(code_cnt_w)) dut0 (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.lane             (lane),
		.byte_aligned     (byte_aligned),
		.sync_done        (sync_done),
		.ttc_resync       (ttc_resync),
		.rst_done         (rst_done),
		.phase_align_rst  (phase_align_rst),
		.calign           (calign),
		.slots            (slots),
		.frame            (frame),
		.frame_valid      (frame_valid),
		.link             (link),
		.notintable_count (notintable_count),
		.disperr_count    (disperr_count)
	);

	initial begin
		CMP_RX_CLK160 = 1'b0;
		forever #2 CMP_RX_CLK160 = ~CMP_RX_CLK160;   // 4 ns period
	end

	always @(posedge CMP_RX_CLK160) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout: tests did not finish within %0d cycles", max_cycles);
			$display("Regression failed");
			$fatal(1, "Run stopped on timeout");
		end
	end

	// Sampled mid-cycle, outputs settled
	always @(negedge CMP_RX_CLK160) begin
		if (frame_valid)
			got_frames.push_back(frame);
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic check(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("Error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
			$display("Regression failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// One lane word, 1 ns after the edge
	task automatic drive_word(input logic [15:0] data, input logic [1:0] isk,
		input logic [1:0] nit, input logic [1:0] derr);
		@(posedge CMP_RX_CLK160);
		#1;
		lane.word.data     = data;
		lane.isk           = isk;
		lane.notintable    = nit;
		lane.disperr       = derr;
		lane.lossofsync_hi = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n)
			drive_word(16'h0000, 2'b00, 2'b00, 2'b00);
	endtask

	// Marker then three data words, mask bit i flags slot i (bit 0 is the marker)
	task automatic send_frame(input logic [7:0] kchar, input logic [15:0] w1, w2, w3,
		input logic [3:0] nit_mask, input logic [3:0] derr_mask);
		drive_word({8'h5A, kchar}, cmp_rx_pkg::k_low_isk, {1'b0, nit_mask[0]},
			{derr_mask[0], 1'b0});
		drive_word(w1, 2'b00, {1'b0, nit_mask[1]}, {derr_mask[1], 1'b0});
		drive_word(w2, 2'b00, {1'b0, nit_mask[2]}, {derr_mask[2], 1'b0});
		drive_word(w3, 2'b00, {1'b0, nit_mask[3]}, {derr_mask[3], 1'b0});
	endtask

	task automatic send_clean_frame();
		send_frame(8'hBC, 16'($random(seed)), 16'($random(seed)), 16'($random(seed)),
			4'b0000, 4'b0000);
	endtask

	// Word 3 on top, then nonzero flags, latency bit last
	function automatic logic [51:0] expect_frame(input logic [15:0] w1, w2, w3,
		input logic lt);
		return {w3, w2, w1, |w3, |w2, |w1, lt};
	endfunction

	task automatic wait_frames(input int n);
		while (got_frames.size() < n)
			@(posedge CMP_RX_CLK160);
	endtask

	task automatic pulse_resync();
		ttc_resync = 1'b1;
		idle(3);   // Long enough to drain the slot ring
		ttc_resync = 1'b0;
	endtask

	task automatic check_cleared();
		check("notintable_count", 0, notintable_count);
		check("disperr_count", 0, disperr_count);
		check("link_good", 0, link.link_good);
		check("link_bad", 0, link.link_bad);
		check("err_count", 0, link.err_count);
		check("frame_valid", 0, frame_valid);
		check("frame", 0, frame);
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic test_reset_idle();
		test_name = "reset_idle";
		repeat (2)
			@(posedge CMP_RX_CLK160);
		#1;
		check("rst_done in reset", 0, rst_done);
		check("phase_align_rst in reset", 1, phase_align_rst);
		check("calign in reset", 1, calign);
		cmp_rx_resetdone = 1'b1;
		@(posedge CMP_RX_CLK160);
		#1;
		check("rst_done edge 1", 0, rst_done);   // Only first stage set
		@(posedge CMP_RX_CLK160);
		#1;
		check("rst_done edge 2", 1, rst_done);
		check("phase_align_rst edge 2", 1, phase_align_rst);
		@(posedge CMP_RX_CLK160);
		#1;
		check("phase_align_rst edge 3", 0, phase_align_rst);
		byte_aligned = 1'b1;
		check("calign before edge", 1, calign);
		@(posedge CMP_RX_CLK160);
		#1;
		check("calign after edge", 0, calign);
		idle(4);
		check("frame_valid idle", 0, frame_valid);
		check("link_good idle", 0, link.link_good);
		check("notintable idle", 0, notintable_count);
		check("disperr idle", 0, disperr_count);
		// Lone marker walks the ring, cew1 first and cew0 last
		drive_word({8'h5A, 8'hBC}, cmp_rx_pkg::k_low_isk, 2'b00, 2'b00);
		check("slots on marker", 4'b0000, slots);
		idle(1);
		check("slots cew1", 4'b0100, slots);
		idle(1);
		check("slots cew2", 4'b0010, slots);
		idle(1);
		check("slots cew3", 4'b0001, slots);
		idle(1);
		check("slots cew0", 4'b1000, slots);
		idle(1);
		check("slots drained", 4'b0000, slots);
	endtask

	task automatic test_frame_assembly();
		logic [7:0]  kchar;
		logic [15:0] w1;
		logic [15:0] w2;
		logic [15:0] w3;
		logic [51:0] expected[$];
		test_name = "frame_assembly";
		got_frames.delete();
		for (int i = 0; i < 4; i++) begin
			kchar = (i % 2 == 1) ? 8'hBC : cmp_rx_pkg::ltncy_char;
			w1 = (i == 1) ? 16'h0000 : 16'($random(seed));   // Zero word in frame 1
			w2 = 16'($random(seed));
			w3 = (i == 0) ? 16'h0000 : 16'($random(seed));
			send_frame(kchar, w1, w2, w3, 4'b0000, 4'b0000);
			// Trigger needs FC in a cew0 slot, never on the first frame
			expected.push_back(expect_frame(w1, w2, w3,
				(kchar == cmp_rx_pkg::ltncy_char) && (i > 0)));
		end
		wait_frames(4);
		idle(6);
		check("frame count", 4, got_frames.size());   // One pulse per frame
		foreach (expected[i])
			check("frame", expected[i], got_frames[i]);
	endtask

	task automatic test_link_lock();
		test_name = "link_lock";
		// First frame never clean, lock lands on the marker after lock_frames+1 frames
		repeat (lock_frames + 2)
			send_clean_frame();
		check("link_good", 1, link.link_good);
		check("link_had_err", 0, link.link_had_err);
		check("err_count", 0, link.err_count);
		check("notintable_count", 0, notintable_count);
		check("disperr_count", 0, disperr_count);
	endtask

	task automatic test_link_loss();
		test_name = "link_loss";
		send_frame(8'hBC, 16'($random(seed)), 16'($random(seed)), 16'($random(seed)),
			4'b0100, 4'b0000);   // Bad second data word
		// Two clean frames settle the monitor again
		send_clean_frame();
		send_clean_frame();
		check("link_good", 0, link.link_good);
		check("link_had_err", 1, link.link_had_err);
		check("err_count", 1, link.err_count);
		check("link_bad", 0, link.link_bad);
		check("notintable_count", 1, notintable_count);
	endtask

	task automatic test_code_errors();
		logic [3:0] nit_a;
		logic [3:0] derr_a;
		logic [3:0] nit_b;
		logic [3:0] derr_b;
		int         k;
		int         m;
		test_name = "code_errors";
		// Losing phase sync clears as well
		sync_done = 1'b0;
		idle(3);
		sync_done = 1'b1;
		check_cleared();
		nit_a  = 4'b0010;
		derr_a = 4'b1100;
		nit_b  = 4'b1001;   // Marker flagged too
		derr_b = 4'b0110;
		// First marker after a clear sits in no slot
		k = $countones(nit_a & 4'b1110) + $countones(nit_b);
		m = $countones(derr_a & 4'b1110) + $countones(derr_b);
		send_frame(8'hBC, 16'($random(seed)), 16'($random(seed)), 16'($random(seed)),
			nit_a, derr_a);
		send_frame(8'hBC, 16'($random(seed)), 16'($random(seed)), 16'($random(seed)),
			nit_b, derr_b);
		send_clean_frame();
		idle(2);
		check("notintable_count", k, notintable_count);
		check("disperr_count", m, disperr_count);
		pulse_resync();
		check_cleared();
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		seed             = 32'h5a1c_13a8;
		cmp_rx_resetdone = 1'b0;
		lane             = '0;
		byte_aligned     = 1'b0;
		sync_done        = 1'b1;   // External aligner already done
		ttc_resync       = 1'b0;
		test_reset_idle();
		test_frame_assembly();
		test_link_lock();
		test_link_loss();
		test_code_errors();
		if (dut0.props0.assert_fails != 0) begin
			$display("Assertion checks failed %0d times", dut0.props0.assert_fails);
			$display("Regression failed");
			$fatal(1, "Run stopped on assertion failures");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: project.f
src/cmp_rx_pkg.sv
src/cmp_rx_lane_ctrl.sv
src/cmp_rx_slot_timer.sv
src/cmp_rx_frame_assembler.sv
src/cmp_rx_link_monitor.sv
src/cmp_rx_code_err_counter.sv
src/cmp_rx_fiber_in.sv
tests/cmp_rx_fiber_in_properties.sv
tests/cmp_rx_fiber_in_tb.sv

// File: Bender.yml
package:
  name: cmp_rx_fiber_in

sources:
  - files:
      - src/cmp_rx_pkg.sv
      - src/cmp_rx_lane_ctrl.sv
      - src/cmp_rx_slot_timer.sv
      - src/cmp_rx_frame_assembler.sv
      - src/cmp_rx_link_monitor.sv
      - src/cmp_rx_code_err_counter.sv
      - src/cmp_rx_fiber_in.sv
  - target: test
    files:
      - tests/cmp_rx_fiber_in_properties.sv
      - tests/cmp_rx_fiber_in_tb.sv
